// File: hw/memgame_pkg.sv
// shared widths, types, card pair table, segment table, register map and reset values
package memgame_pkg;

	localparam int NUM_CARDS = 18; // nine pairs on the board

	typedef logic [NUM_CARDS-1:0] card_vec_t; // one bit per card
	typedef logic [4:0] card_idx_t; // card number 0..17
	typedef logic [3:0] bcd_t; // one decimal digit
	typedef logic [6:0] seg_t; // active low, bit 0 is segment a
	typedef logic [27:0] tick_t; // prescaler count
	typedef logic [7:0] secs_t; // two decimal digits of seconds
	typedef logic player_t; // 0 is player one
	typedef logic [3:0] apb_addr_t; // byte address
	typedef logic [31:0] apb_data_t;

	typedef enum logic [2:0] {
		choose_first, // waiting for first press
		choose_first_wait, // first card taken, waiting for release
		choose_second,
		choose_second_wait,
		judge, // third press compares the pair
		judge_wait
	} turn_state_e;

	// partner of each card, indexed by card number
	localparam card_idx_t CARD_PARTNER [NUM_CARDS] = '{
		5'd16, 5'd6, 5'd13, 5'd14, 5'd15, 5'd8, // cards 0..5
		5'd1, 5'd9, 5'd5, 5'd7, 5'd17, 5'd12, // cards 6..11
		5'd11, 5'd2, 5'd3, 5'd4, 5'd0, 5'd10 // cards 12..17
	};

	// digits 0..9, active low gfedcba
	localparam seg_t SEG_TABLE [10] = '{
		7'b1000000, // 0
		7'b1111001, // 1
		7'b0100100, // 2
		7'b0110000, // 3
		7'b0011001, // 4
		7'b0010010, // 5
		7'b0000010, // 6
		7'b1111000, // 7
		7'b0000000, // 8
		7'b0011000 // 9
	};

	localparam tick_t TICK_RELOAD_DEFAULT = 28'd49_999_999; // one second at 50 MHz
	localparam secs_t TURN_START_DEFAULT = 8'h60; // 60 s as two digits

	localparam apb_addr_t ADDR_CTRL = 4'h0; // bit 0 timer_run
	localparam apb_addr_t ADDR_TICK = 4'h4; // prescaler reload
	localparam apb_addr_t ADDR_START = 4'h8; // countdown start
	localparam apb_addr_t ADDR_STATUS = 4'hC; // read only game status

endpackage

// File: hw/seg7_decode.sv
// one decimal digit to active-low seven-segment pattern
`timescale 1ns/1ps

module seg7_decode (
	input memgame_pkg::bcd_t digit,
	output memgame_pkg::seg_t seg // bit 0 is segment a
);

	always_comb
	begin
		if (digit <= 4'd9)
			seg = memgame_pkg::SEG_TABLE[digit];
		else
			seg = 7'b1111111; // blank for non-decimal codes
	end

endmodule

// File: hw/turn_fsm.sv
// turn FSM turning go presses into take and judge pulses
`timescale 1ns/1ps

module turn_fsm (
	input logic clock,
	input logic reset_n,
	input logic go, // high while button held
	output logic take_first, // latch first card
	output logic take_second, // latch second card
	output logic judge_now // compare the pair
);

	memgame_pkg::turn_state_e state;
	memgame_pkg::turn_state_e state_next;

	// press moves to wait, release moves on
	always_comb
	begin
		state_next = state;
		case (state)
			memgame_pkg::choose_first:
				if (go) state_next = memgame_pkg::choose_first_wait;
			memgame_pkg::choose_first_wait:
				if (!go) state_next = memgame_pkg::choose_second;
			memgame_pkg::choose_second:
				if (go) state_next = memgame_pkg::choose_second_wait;
			memgame_pkg::choose_second_wait:
				if (!go) state_next = memgame_pkg::judge;
			memgame_pkg::judge:
				if (go) state_next = memgame_pkg::judge_wait;
			memgame_pkg::judge_wait:
				if (!go) state_next = memgame_pkg::choose_first; // back to the start of a turn
			default:
				state_next = memgame_pkg::choose_first;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (!reset_n)
		begin
			state <= memgame_pkg::choose_first;
			take_first <= 1'b0;
			take_second <= 1'b0;
			judge_now <= 1'b0;
		end
		else
		begin
			state <= state_next;
			// each pulse lines up with entry to its wait state
			take_first <= (state == memgame_pkg::choose_first) && go;
			take_second <= (state == memgame_pkg::choose_second) && go;
			judge_now <= (state == memgame_pkg::judge) && go;
		end
	end

	// pair_judge relies on never seeing two commands at once
	assert property (@(posedge clock) disable iff (!reset_n)
		$onehot0({take_first, take_second, judge_now}));

endmodule

// File: hw/pair_judge.sv
// pair judge with card latches, partner check and cleared-card mask
`timescale 1ns/1ps

module pair_judge (
	input logic clock,
	input logic reset_n,
	input logic take_first, // latch card_sel as first card
	input logic take_second, // latch card_sel as second card
	input logic judge_now, // compare the two latched cards
	input memgame_pkg::card_vec_t card_sel,
	output logic result_valid, // one cycle after judge_now
	output logic result_hit, // pair was correct
	output memgame_pkg::bcd_t pairs_cleared // pairs taken off the board
);

	memgame_pkg::card_vec_t first_vec; // latched selections
	memgame_pkg::card_vec_t second_vec;
	memgame_pkg::card_vec_t cleared; // cards already matched
	memgame_pkg::card_idx_t first_idx;
	memgame_pkg::card_vec_t partner_vec; // one-hot partner of first card
	logic hit;

	// lowest set bit of a one-hot vector
	function automatic memgame_pkg::card_idx_t vec_to_idx(input memgame_pkg::card_vec_t vec);
		memgame_pkg::card_idx_t idx;
		idx = '0;
		for (int i = memgame_pkg::NUM_CARDS - 1; i >= 0; i--)
		begin
			if (vec[i])
				idx = memgame_pkg::card_idx_t'(i);
		end
		return idx;
	endfunction

	assign first_idx = vec_to_idx(first_vec);
	assign partner_vec = memgame_pkg::card_vec_t'(1) << memgame_pkg::CARD_PARTNER[first_idx];

	assign hit = $onehot(first_vec) && $onehot(second_vec) // exactly one card each
		&& (((first_vec | second_vec) & cleared) == '0) // neither already gone
		&& (second_vec == partner_vec);

	always_ff @(posedge clock)
	begin
		if (take_first)
			first_vec <= card_sel;
		if (take_second)
			second_vec <= card_sel;
	end

	always_ff @(posedge clock)
	begin
		if (!reset_n)
		begin
			cleared <= '0;
			pairs_cleared <= '0;
			result_valid <= 1'b0;
			result_hit <= 1'b0;
		end
		else
		begin
			result_valid <= judge_now;
			result_hit <= judge_now && hit;
			if (judge_now && hit)
			begin
				cleared <= cleared | first_vec | second_vec; // both cards leave play
				pairs_cleared <= pairs_cleared + 4'd1; // at most nine
			end
		end
	end

	// a cleared card stays cleared until reset
	assert property (@(posedge clock) disable iff (!reset_n)
		$past(reset_n) |-> ((cleared & $past(cleared)) == $past(cleared)));

endmodule

// File: hw/score_keeper.sv
// turn owner and the two decimal score digits
`timescale 1ns/1ps

module score_keeper (
	input logic clock,
	input logic reset_n,
	input logic result_valid, // judge outcome strobe
	input logic result_hit,
	output memgame_pkg::player_t cur_player,
	output memgame_pkg::bcd_t score_p1,
	output memgame_pkg::bcd_t score_p2
);

	// count up with wrap 9 to 0
	function automatic memgame_pkg::bcd_t bcd_inc(input memgame_pkg::bcd_t d);
		return (d >= 4'd9) ? 4'd0 : d + 4'd1;
	endfunction

	always_ff @(posedge clock)
	begin
		if (!reset_n)
		begin
			cur_player <= 1'b0; // player one starts
			score_p1 <= '0;
			score_p2 <= '0;
		end
		else if (result_valid)
		begin
			if (!result_hit)
				cur_player <= ~cur_player; // miss passes the turn
			else if (cur_player == 1'b0)
				score_p1 <= bcd_inc(score_p1);
			else
				score_p2 <= bcd_inc(score_p2);
		end
	end

	assert property (@(posedge clock) disable iff (!reset_n)
		(score_p1 <= 4'd9) && (score_p2 <= 4'd9));

endmodule

// File: hw/countdown_timer.sv
// prescaler and two-digit decimal seconds countdown
`timescale 1ns/1ps

module countdown_timer (
	input logic clock,
	input logic reset_n,
	input logic timer_run, // low freezes everything
	input memgame_pkg::tick_t tick_reload, // cycles per second minus one
	input memgame_pkg::secs_t turn_start, // loaded when count hits 00
	output memgame_pkg::secs_t secs
);

	memgame_pkg::tick_t prescale;
	logic tick; // one second elapsed
	memgame_pkg::bcd_t secs_lo;
	memgame_pkg::bcd_t secs_hi;

	assign tick = (prescale == '0);
	assign secs_lo = secs[3:0];
	assign secs_hi = secs[7:4];

	always_ff @(posedge clock)
	begin
		if (!reset_n)
		begin
			prescale <= memgame_pkg::TICK_RELOAD_DEFAULT;
			secs <= memgame_pkg::TURN_START_DEFAULT;
		end
		else if (timer_run)
		begin
			// a shorter reload written mid-count restarts the prescaler
			if (prescale > tick_reload)
				prescale <= tick_reload;
			else if (tick)
			begin
				prescale <= tick_reload;
				if (secs == '0)
					secs <= turn_start; // wrap to start value
				else if (secs_lo == 4'd0)
					secs <= {secs_hi - 4'd1, 4'd9}; // borrow from tens
				else
					secs <= {secs_hi, secs_lo - 4'd1};
			end
			else
				prescale <= prescale - 28'd1;
		end
	end

	assert property (@(posedge clock) disable iff (!reset_n)
		(secs_lo <= 4'd9) && (secs_hi <= 4'd9));

endmodule

// File: hw/game_regs.sv
// APB slave with timer control, tick reload, start value and game status
`timescale 1ns/1ps

module game_regs (
	input logic clock,
	input logic reset_n,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input memgame_pkg::apb_addr_t paddr,
	input memgame_pkg::apb_data_t pwdata,
	input memgame_pkg::player_t cur_player,
	input memgame_pkg::bcd_t score_p1,
	input memgame_pkg::bcd_t score_p2,
	input memgame_pkg::bcd_t pairs_cleared,
	output memgame_pkg::apb_data_t prdata,
	output logic pready,
	output logic pslverr,
	output logic timer_run,
	output memgame_pkg::tick_t tick_reload,
	output memgame_pkg::secs_t turn_start
);

	logic access; // APB access phase
	logic addr_ok;
	logic wr_en;

	// each digit saturates at 9 so the countdown stays decimal
	function automatic memgame_pkg::secs_t to_secs(input memgame_pkg::apb_data_t data);
		memgame_pkg::bcd_t hi;
		memgame_pkg::bcd_t lo;
		hi = (data[7:4] > 4'd9) ? 4'd9 : data[7:4];
		lo = (data[3:0] > 4'd9) ? 4'd9 : data[3:0];
		return {hi, lo};
	endfunction

	assign access = psel && penable;
	assign addr_ok = (paddr == memgame_pkg::ADDR_CTRL) || (paddr == memgame_pkg::ADDR_TICK)
		|| (paddr == memgame_pkg::ADDR_START) || (paddr == memgame_pkg::ADDR_STATUS);
	assign pready = 1'b1; // no wait states
	assign pslverr = access && (!addr_ok || (pwrite && paddr == memgame_pkg::ADDR_STATUS));
	assign wr_en = access && pwrite && !pslverr;

	always_ff @(posedge clock)
	begin
		if (!reset_n)
		begin
			timer_run <= 1'b1; // timer runs out of reset
			tick_reload <= memgame_pkg::TICK_RELOAD_DEFAULT;
			turn_start <= memgame_pkg::TURN_START_DEFAULT;
		end
		else if (wr_en)
		begin
			case (paddr)
				memgame_pkg::ADDR_CTRL: timer_run <= pwdata[0];
				memgame_pkg::ADDR_TICK: tick_reload <= pwdata[27:0];
				memgame_pkg::ADDR_START: turn_start <= to_secs(pwdata);
				default: ; // status is read only
			endcase
		end
	end

	always_comb
	begin
		case (paddr)
			memgame_pkg::ADDR_CTRL: prdata = {31'd0, timer_run};
			memgame_pkg::ADDR_TICK: prdata = {4'd0, tick_reload};
			memgame_pkg::ADDR_START: prdata = {24'd0, turn_start};
			memgame_pkg::ADDR_STATUS:
				prdata = {19'd0, pairs_cleared, cur_player, score_p2, score_p1};
			default: prdata = '0; // unknown address
		endcase
	end

	// access phase only follows a selected setup phase
	assert property (@(posedge clock) disable iff (!reset_n) penable |-> psel);

endmodule

// File: hw/memgame_top.sv
// game core top level with turn FSM, pair judge, scores, timer, APB registers and displays
`timescale 1ns/1ps

module memgame_top (
	input logic clock,
	input logic reset_n,
	input logic go, // go button, high while pressed
	input memgame_pkg::card_vec_t card_sel, // one-hot card switches
	input logic psel,
	input logic penable,
	input logic pwrite,
	input memgame_pkg::apb_addr_t paddr,
	input memgame_pkg::apb_data_t pwdata,
	output memgame_pkg::apb_data_t prdata,
	output logic pready,
	output logic pslverr,
	output memgame_pkg::seg_t hex_p1, // player one score
	output memgame_pkg::seg_t hex_p2, // player two score
	output memgame_pkg::seg_t hex_sec_lo, // seconds, units
	output memgame_pkg::seg_t hex_sec_hi, // seconds, tens
	output memgame_pkg::player_t player // whose turn
);

	logic take_first; // turn_fsm to pair_judge
	logic take_second;
	logic judge_now;
	logic result_valid; // pair_judge to score_keeper
	logic result_hit;
	memgame_pkg::bcd_t pairs_cleared;
	memgame_pkg::player_t cur_player;
	memgame_pkg::bcd_t score_p1;
	memgame_pkg::bcd_t score_p2;
	logic timer_run; // timer config from registers
	memgame_pkg::tick_t tick_reload;
	memgame_pkg::secs_t turn_start;
	memgame_pkg::secs_t secs;

	turn_fsm i_turn_fsm (.clock, .reset_n, .go, .take_first, .take_second, .judge_now);

	pair_judge i_pair_judge (.clock, .reset_n, .take_first, .take_second, .judge_now,
		.card_sel, .result_valid, .result_hit, .pairs_cleared);

	score_keeper i_score_keeper (.clock, .reset_n, .result_valid, .result_hit,
		.cur_player, .score_p1, .score_p2);

	countdown_timer i_countdown_timer (.clock, .reset_n, .timer_run, .tick_reload,
		.turn_start, .secs);

	game_regs i_game_regs (.clock, .reset_n, .psel, .penable, .pwrite, .paddr, .pwdata,
		.cur_player, .score_p1, .score_p2, .pairs_cleared, .prdata, .pready, .pslverr,
		.timer_run, .tick_reload, .turn_start);

	seg7_decode i_seg_p1 (.digit(score_p1), .seg(hex_p1));
	seg7_decode i_seg_p2 (.digit(score_p2), .seg(hex_p2));
	seg7_decode i_seg_sec_lo (.digit(secs[3:0]), .seg(hex_sec_lo)); // units digit
	seg7_decode i_seg_sec_hi (.digit(secs[7:4]), .seg(hex_sec_hi)); // tens digit

	assign player = cur_player;

endmodule

// File: bench/memgame_checker.sv
// reference model of the game rules with value checks and per-test result lines
`timescale 1ns/1ps

module memgame_checker (
	input memgame_pkg::seg_t hex_p1,
	input memgame_pkg::seg_t hex_p2,
	input memgame_pkg::player_t player
);

	memgame_pkg::card_vec_t cleared; // model of matched cards
	memgame_pkg::bcd_t score [2]; // index 0 is player one
	logic cur; // model turn owner
	int pairs;
	int err_count = 0;
	int check_count = 0;
	int test_count = 0;
	int test_fails = 0;
	int test_errs = 0; // errors in the running test

	// active low gfedcba for 0..9
	logic [6:0] seg_ref [10] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19,
		7'h12, 7'h02, 7'h78, 7'h00, 7'h18};

	// partner card from the board's pair list
	function automatic int partner_of(input int c);
		case (c)
			17: return 10;
			10: return 17;
			16: return 0;
			0: return 16;
			15: return 4;
			4: return 15;
			14: return 3;
			3: return 14;
			13: return 2;
			2: return 13;
			12: return 11;
			11: return 12;
			9: return 7;
			7: return 9;
			8: return 5;
			5: return 8;
			6: return 1;
			1: return 6;
			default: return -1;
		endcase
	endfunction

	// segment pattern back to its digit or 15
	function automatic memgame_pkg::bcd_t digit_of(input memgame_pkg::seg_t s);
		for (int i = 0; i < 10; i++)
		begin
			if (seg_ref[i] == s)
				return memgame_pkg::bcd_t'(i);
		end
		return 4'hF;
	endfunction

	function automatic logic [31:0] status_exp();
		return {19'd0, 4'(pairs), cur, score[1], score[0]};
	endfunction

	task automatic model_reset();
		cleared = '0;
		score[0] = '0;
		score[1] = '0;
		cur = 1'b0; // player one starts
		pairs = 0;
	endtask

	// apply one judged turn where a hit keeps the turn
	task automatic model_turn(input memgame_pkg::card_vec_t a, input memgame_pkg::card_vec_t b);
		int ia;
		logic hit;
		ia = 0;
		hit = $onehot(a) && $onehot(b) && (((a | b) & cleared) == '0);
		if (hit)
		begin
			for (int i = 0; i < memgame_pkg::NUM_CARDS; i++)
			begin
				if (a[i])
					ia = i;
			end
			hit = (b == (memgame_pkg::card_vec_t'(1) << partner_of(ia)));
		end
		if (hit)
		begin
			cleared = cleared | a | b;
			score[cur] = (score[cur] == 4'd9) ? 4'd0 : score[cur] + 4'd1; // wraps 9 to 0
			pairs++;
		end
		else
			cur = ~cur; // miss passes the turn
	endtask

	task automatic check_val(input string test, input string what, input logic [31:0] exp,
		input logic [31:0] act);
		check_count++;
		if (exp !== act)
		begin
			$display("ERR %s %s expected %0h actual %0h", test, what, exp, act);
			err_count++;
			test_errs++;
		end
	endtask

	task automatic note_fail(input string test, input string what);
		$display("test %s went wrong, %s", test, what);
		err_count++;
		test_errs++;
	endtask

	task automatic check_game(input string test);
		check_val(test, "hex_p1", seg_ref[score[0]], hex_p1);
		check_val(test, "hex_p2", seg_ref[score[1]], hex_p2);
		check_val(test, "player", cur, player);
	endtask

	task automatic test_done(input string test);
		test_count++;
		if (test_errs == 0)
			$display("test %s ok", test);
		else
		begin
			$display("test %s failed with %0d errors", test, test_errs);
			test_fails++;
		end
		test_errs = 0;
	endtask

	task automatic report();
		$display("tests %0d, failed %0d, checks %0d, errors %0d", test_count, test_fails,
			check_count, err_count);
	endtask

endmodule

// File: bench/tb_memgame.sv
// testbench top with clock, reset, APB tasks, random turns, timer and error tests
`timescale 1ns/1ps

module tb_memgame;

	localparam int PERIOD = 40;
	localparam int DRIVE = 2; // input delay after rising edge
	localparam int WAIT_LIMIT = 1000;

	logic clock;
	logic reset_n;
	logic go;
	memgame_pkg::card_vec_t card_sel;
	logic psel;
	logic penable;
	logic pwrite;
	memgame_pkg::apb_addr_t paddr;
	memgame_pkg::apb_data_t pwdata;
	memgame_pkg::apb_data_t prdata;
	logic pready;
	logic pslverr;
	memgame_pkg::seg_t hex_p1;
	memgame_pkg::seg_t hex_p2;
	memgame_pkg::seg_t hex_sec_lo;
	memgame_pkg::seg_t hex_sec_hi;
	memgame_pkg::player_t player;

	memgame_top i_dut (.clock, .reset_n, .go, .card_sel, .psel, .penable, .pwrite, .paddr,
		.pwdata, .prdata, .pready, .pslverr, .hex_p1, .hex_p2, .hex_sec_lo, .hex_sec_hi,
		.player);

	memgame_checker i_chk (.hex_p1, .hex_p2, .player);

	initial
	begin
		clock = 1'b0;
		forever #(PERIOD / 2) clock = ~clock;
	end

	task automatic stop_on_timeout(input string what);
		$display("timeout, %s", what);
		$display("RESULT: FAIL");
		$finish;
	endtask

	task automatic apply_reset();
		@(posedge clock);
		#DRIVE;
		reset_n = 1'b0;
		go = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		repeat (3) @(posedge clock);
		#DRIVE;
		reset_n = 1'b1;
	endtask

	// setup cycle then access cycle sampled before the closing edge
	task automatic apb_access(input logic wr, input memgame_pkg::apb_addr_t addr,
		input memgame_pkg::apb_data_t wdata, output memgame_pkg::apb_data_t rdata,
		output logic err);
		int n;
		n = 0;
		@(posedge clock);
		#DRIVE;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = addr;
		pwdata = wdata;
		@(posedge clock);
		#DRIVE;
		penable = 1'b1;
		@(negedge clock);
		while (!pready)
		begin
			n++;
			if (n > WAIT_LIMIT)
				stop_on_timeout("APB transfer never completed");
			@(negedge clock);
		end
		rdata = prdata;
		err = pslverr;
		@(posedge clock);
		#DRIVE;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	// card_sel turns to junk after the latch two edges in
	task automatic press_go(input memgame_pkg::card_vec_t card, input int hold);
		@(posedge clock);
		#DRIVE;
		card_sel = card;
		go = 1'b1;
		repeat (2) @(posedge clock);
		#DRIVE;
		card_sel = memgame_pkg::card_vec_t'($urandom);
		repeat (hold - 2) @(posedge clock);
		#DRIVE;
		go = 1'b0;
		repeat (2) @(posedge clock);
	endtask

	task automatic play_turn(input memgame_pkg::card_vec_t a, input memgame_pkg::card_vec_t b,
		input int hold);
		i_chk.model_turn(a, b);
		press_go(a, hold);
		press_go(b, hold);
		press_go(memgame_pkg::card_vec_t'($urandom), hold); // judge press
	endtask

	task automatic check_status(input string test);
		memgame_pkg::apb_data_t d;
		logic e;
		apb_access(1'b0, memgame_pkg::ADDR_STATUS, '0, d, e);
		i_chk.check_val(test, "status", i_chk.status_exp(), d);
	endtask

	// first card index at or after a random start whose cleared bit equals want
	function automatic int find_card(input logic want);
		int s;
		s = $urandom % memgame_pkg::NUM_CARDS;
		for (int i = 0; i < memgame_pkg::NUM_CARDS; i++)
		begin
			if (i_chk.cleared[(s + i) % memgame_pkg::NUM_CARDS] == want)
				return (s + i) % memgame_pkg::NUM_CARDS;
		end
		return -1;
	endfunction

	function automatic memgame_pkg::secs_t shown_secs();
		return {i_chk.digit_of(hex_sec_hi), i_chk.digit_of(hex_sec_lo)};
	endfunction

	// one second less as a plain number, start value again after 00
	function automatic memgame_pkg::secs_t next_secs(input memgame_pkg::secs_t s,
		input memgame_pkg::secs_t start);
		int v;
		v = 10 * s[7:4] + s[3:0];
		if (v == 0)
			return start;
		v = v - 1;
		return {4'(v / 10), 4'(v % 10)};
	endfunction

	initial
	begin
		memgame_pkg::apb_data_t d;
		memgame_pkg::apb_data_t save [3];
		memgame_pkg::card_vec_t a;
		memgame_pkg::card_vec_t b;
		memgame_pkg::secs_t cur;
		memgame_pkg::secs_t now;
		memgame_pkg::secs_t exp;
		memgame_pkg::secs_t st;
		logic e;
		int c;
		int r;
		int n;
		go = 1'b0;
		card_sel = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		reset_n = 1'b0;
		void'($urandom(32'h10a1)); // one seed for the whole run
		apply_reset();
		i_chk.model_reset();

		check_status("reset");
		i_chk.check_game("reset");
		apb_access(1'b0, memgame_pkg::ADDR_TICK, '0, d, e);
		i_chk.check_val("reset", "tick", 32'd49_999_999, d);
		apb_access(1'b0, memgame_pkg::ADDR_START, '0, d, e);
		i_chk.check_val("reset", "start", 32'h60, d);
		i_chk.test_done("reset");

		for (int t = 0; t < 64; t++)
		begin
			if (i_chk.pairs == 9)
			begin
				apply_reset(); // empty board starts a new game
				i_chk.model_reset();
			end
			a = memgame_pkg::card_vec_t'(1) << ($urandom % memgame_pkg::NUM_CARDS);
			b = memgame_pkg::card_vec_t'(1) << ($urandom % memgame_pkg::NUM_CARDS);
			case ($urandom % 5)
				0, 1:
				begin
					c = find_card(1'b0); // true pair of live cards
					a = memgame_pkg::card_vec_t'(1) << c;
					b = memgame_pkg::card_vec_t'(1) << i_chk.partner_of(c);
				end
				2:
				begin
					a = memgame_pkg::card_vec_t'($urandom); // not one-hot
					if ($onehot(a))
						a = '0;
				end
				3:
				begin
					c = find_card(1'b1); // already cleared card
					if (c >= 0)
					begin
						a = memgame_pkg::card_vec_t'(1) << c;
						b = memgame_pkg::card_vec_t'(1) << i_chk.partner_of(c);
					end
				end
				default: ; // random one-hot pair that is usually wrong
			endcase
			play_turn(a, b, 3 + $urandom % 3);
			i_chk.check_game("random turns");
			check_status("random turns");
		end
		i_chk.test_done("random turns");

		apply_reset();
		i_chk.model_reset();
		play_turn(18'h00001, 18'h10000, 9); // long holds with junk on card_sel
		i_chk.check_game("held press");
		repeat (10) @(posedge clock);
		i_chk.check_game("held press");
		play_turn(18'h00002, 18'h00040, 12);
		i_chk.check_game("held press");
		check_status("held press");
		i_chk.test_done("held press");

		apb_access(1'b0, memgame_pkg::ADDR_CTRL, '0, save[0], e);
		apb_access(1'b0, memgame_pkg::ADDR_TICK, '0, save[1], e);
		apb_access(1'b0, memgame_pkg::ADDR_START, '0, save[2], e);
		apb_access(1'b0, 4'h2, '0, d, e);
		i_chk.check_val("apb errors", "read 0x2 pslverr", 1, e);
		apb_access(1'b0, 4'hE, '0, d, e);
		i_chk.check_val("apb errors", "read 0xE pslverr", 1, e);
		apb_access(1'b1, memgame_pkg::ADDR_STATUS, 32'hFFFF_FFFF, d, e);
		i_chk.check_val("apb errors", "status write pslverr", 1, e);
		apb_access(1'b1, 4'h6, 32'h0000_0003, d, e);
		i_chk.check_val("apb errors", "write 0x6 pslverr", 1, e);
		apb_access(1'b0, memgame_pkg::ADDR_CTRL, '0, d, e);
		i_chk.check_val("apb errors", "ctrl kept", save[0], d);
		i_chk.check_val("apb errors", "good read pslverr", 0, e);
		apb_access(1'b0, memgame_pkg::ADDR_TICK, '0, d, e);
		i_chk.check_val("apb errors", "tick kept", save[1], d);
		apb_access(1'b0, memgame_pkg::ADDR_START, '0, d, e);
		i_chk.check_val("apb errors", "start kept", save[2], d);
		check_status("apb errors");
		i_chk.test_done("apb errors");

		r = 2 + $urandom % 4;
		st = {4'($urandom % 3), 4'($urandom % 10)};
		apb_access(1'b1, memgame_pkg::ADDR_TICK, r, d, e);
		apb_access(1'b1, memgame_pkg::ADDR_START, {24'd0, st}, d, e);
		cur = shown_secs();
		n = 0;
		while (shown_secs() == cur)
		begin
			n++;
			if (n > WAIT_LIMIT)
				stop_on_timeout("seconds display never changed");
			@(posedge clock);
			#DRIVE;
		end
		cur = shown_secs();
		for (int s = 0; s < 75; s++)
		begin
			exp = next_secs(cur, st);
			for (int k = 1; k <= r + 1; k++)
			begin
				@(posedge clock);
				#DRIVE;
				now = shown_secs();
				if (k <= r && now != cur)
					i_chk.note_fail("timer", "seconds changed before the tick");
			end
			i_chk.check_val("timer", "seconds", exp, now);
			cur = now;
		end
		apb_access(1'b1, memgame_pkg::ADDR_CTRL, '0, d, e);
		@(posedge clock);
		#DRIVE;
		cur = shown_secs();
		repeat (4 * (r + 1)) @(posedge clock);
		#DRIVE;
		i_chk.check_val("timer", "frozen seconds", cur, shown_secs());
		i_chk.test_done("timer");

		i_chk.report();
		if (i_chk.err_count == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: all.f
hw/memgame_pkg.sv
hw/seg7_decode.sv
hw/turn_fsm.sv
hw/pair_judge.sv
hw/score_keeper.sv
hw/countdown_timer.sv
hw/game_regs.sv
hw/memgame_top.sv
bench/memgame_checker.sv
bench/tb_memgame.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS ?= --timing --assert
TOP ?= tb_memgame
FILELIST ?= all.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o sim_$(TOP)
	./$(OBJ_DIR)/sim_$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
